//--- include/mipsDatapath_config.svh
`ifndef MIPS_DATAPATH_CONFIG_SVH
`define MIPS_DATAPATH_CONFIG_SVH

`define MIPS_PC_STEP    32'd4
`define MIPS_RESET_PC   32'h0000_0000
`define MIPS_LINK_REG   5'd31

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// primary opcode field, bits 31:26.
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_LUI     6'h0f

// funct field of R-type words, bits 5:0.
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_SLT     6'h2a

`endif

//--- mipsDatapath.f
+incdir+include
src/mipsPkg.sv
src/regFile.sv
src/instrDecode.sv
src/issueLatch.sv
src/aluWriteback.sv
src/mipsDatapath.sv
verif/wbChecker.sv
verif/mipsDatapathTb.sv

//--- src/aluWriteback.sv
`timescale 1ns/1ns
`include "mipsDatapath_config.svh"

module aluWriteback
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     issValid,
	input  aluOp_t   issAluOp,
	input  wbSel_t   issWbSel,
	input  regAddr_t issDest,
	input  word_t    issOpA,
	input  word_t    issOpB,
	input  word_t    issImm,
	input  word_t    issPc,
	input  logic     wbHold,
	output logic     exValid,
	output regAddr_t exDest,
	output word_t    exResult,
	output logic     wrEn,
	output regAddr_t wrAddr,
	output word_t    wrData,
	output logic     wbValid,
	output regAddr_t wbAddr,
	output word_t    wbData
);

	word_t aluOut;
	word_t upperImm;
	word_t linkAddr;
	word_t result;
	logic  retire;

	always_comb begin
		case (issAluOp)
			ALU_ADD:   aluOut = issOpA + issOpB;
			ALU_SUB:   aluOut = issOpA - issOpB;
			ALU_AND:   aluOut = issOpA & issOpB;
			ALU_OR:    aluOut = issOpA | issOpB;
			ALU_SLT:   aluOut = {31'b0, ($signed(issOpA) < $signed(issOpB))};
			ALU_PASSB: aluOut = issOpB;
			default:   aluOut = '0;
		endcase
	end

	assign upperImm = {issImm[15:0], 16'h0000};
	assign linkAddr = issPc + `MIPS_PC_STEP;

	always_comb begin
		case (issWbSel)
			WB_UPPER: result = upperImm;
			WB_LINK:  result = linkAddr;
			default:  result = aluOut;
		endcase
	end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign retire = issValid && !wbHold;

	assign exValid  = issValid; // result offered back to decode for forwarding.
	assign exDest   = issDest;
	assign exResult = result;

	assign wrEn   = retire; // register file updates at the retiring edge.
	assign wrAddr = issDest;
	assign wrData = result;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			wbValid <= 1'b0;
		else
			wbValid <= retire;
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			wbAddr <= issDest;
			wbData <= result;
		end
	end

	// back-to-back retirements are legal, but only for two different instructions.
	assert property (@(posedge clk) disable iff (!rstN)
		retire |=> !retire || (issPc != $past(issPc)))
		else $error("wbValid stayed high for a second cycle of the same instruction.");

endmodule

//--- src/instrDecode.sv
`timescale 1ns/1ns
`include "mipsDatapath_config.svh"

module instrDecode
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     instrReq,
	input  word_t    instrWord,
	output logic     instrAck,
	input  logic     latchFree,
	output regAddr_t rdAddrA,
	output regAddr_t rdAddrB,
	input  word_t    rdDataA,
	input  word_t    rdDataB,
	input  logic     exValid,
	input  regAddr_t exDest,
	input  word_t    exResult,
	output logic     decValid,
	output aluOp_t   decAluOp,
	output wbSel_t   decWbSel,
	output regAddr_t decDest,
	output word_t    decOpA,
	output word_t    decOpB,
	output word_t    decImm,
	output word_t    decPc
);

	hsState_t    state;
	word_t       pc;
	logic [5:0]  opcode;
	logic [5:0]  funct;
	regAddr_t    rs;
	regAddr_t    rt;
	regAddr_t    rd;
	logic [15:0] imm16;
	logic        useImm;
	logic        immSigned;
	word_t       fwdA;
	word_t       fwdB;

	function automatic word_t forwardSel(input regAddr_t src, input word_t regVal,
			input logic inFlight, input regAddr_t inDest, input word_t inData);
		word_t sel;
		if (inFlight && (src == inDest) && (src != '0))
			sel = inData;
		else
			sel = regVal;
		return sel;
	endfunction

	assign opcode = instrWord[31:26];
	assign rs     = instrWord[25:21];
	assign rt     = instrWord[20:16];
	assign rd     = instrWord[15:11];
	assign funct  = instrWord[5:0];
	assign imm16  = instrWord[15:0];

	assign rdAddrA = rs;
	assign rdAddrB = rt;
	assign fwdA = forwardSel(rs, rdDataA, exValid, exDest, exResult);
	assign fwdB = forwardSel(rt, rdDataB, exValid, exDest, exResult);

	assign decValid = (state == IDLE) && instrReq && latchFree; // accepted at the next edge.
	assign decImm = immSigned ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
	assign decOpA = fwdA;
	assign decOpB = useImm ? decImm : fwdB;
	assign decPc  = pc;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		decAluOp  = ALU_ADD;
		decWbSel  = WB_ALU;
		decDest   = rd;
		useImm    = 1'b0;
		immSigned = 1'b0;
		case (opcode)
			`MIPS_OP_RTYPE: begin
				case (funct)
					`MIPS_FN_ADDU: decAluOp = ALU_ADD;
					`MIPS_FN_SUBU: decAluOp = ALU_SUB;
					`MIPS_FN_AND:  decAluOp = ALU_AND;
					`MIPS_FN_OR:   decAluOp = ALU_OR;
					`MIPS_FN_SLT:  decAluOp = ALU_SLT;
					default:       decDest = '0; // unknown funct retires into r0.
				endcase
			end
			`MIPS_OP_ADDIU: begin
				decDest   = rt;
				useImm    = 1'b1;
				immSigned = 1'b1;
			end
			`MIPS_OP_ORI: begin
				decAluOp = ALU_OR;
				decDest  = rt;
				useImm   = 1'b1;
			end
			`MIPS_OP_LUI: begin
				decAluOp = ALU_PASSB;
				decWbSel = WB_UPPER;
				decDest  = rt;
				useImm   = 1'b1;
			end
			`MIPS_OP_JAL: begin
				decAluOp = ALU_PASSB;
				decWbSel = WB_LINK;
				decDest  = `MIPS_LINK_REG;
			end
			default: decDest = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= IDLE;
			instrAck <= 1'b0;
			pc       <= `MIPS_RESET_PC;
		end else begin
			case (state)
				IDLE: begin
					if (decValid) begin
						state    <= ACKED;
						instrAck <= 1'b1;
						pc       <= pc + `MIPS_PC_STEP;
					end
				end
				ACKED, WAITLOW: begin
					if (!instrReq) begin
						state    <= IDLE;
						instrAck <= 1'b0; // falls one cycle after req is seen low.
					end else begin
						state <= WAITLOW;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		instrReq && !instrAck |=> $stable(instrWord))
		else $error("instrWord changed while instrReq waited for instrAck.");

	assert property (@(posedge clk) disable iff (!rstN)
		$rose(instrAck) |-> $past(instrReq))
		else $error("instrAck rose with no request pending.");

endmodule

//--- src/issueLatch.sv
`timescale 1ns/1ns

module issueLatch
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     decValid,
	input  aluOp_t   decAluOp,
	input  wbSel_t   decWbSel,
	input  regAddr_t decDest,
	input  word_t    decOpA,
	input  word_t    decOpB,
	input  word_t    decImm,
	input  word_t    decPc,
	input  logic     wbHold,
	output logic     latchFree,
	output logic     issValid,
	output aluOp_t   issAluOp,
	output wbSel_t   issWbSel,
	output regAddr_t issDest,
	output word_t    issOpA,
	output word_t    issOpB,
	output word_t    issImm,
	output word_t    issPc
);

	assign latchFree = !issValid || !wbHold; // empty, or retiring this cycle.

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			issValid <= 1'b0;
		else if (decValid)
			issValid <= 1'b1;
		else if (!wbHold)
			issValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			issAluOp <= decAluOp;
			issWbSel <= decWbSel;
			issDest  <= decDest;
			issOpA   <= decOpA;
			issOpB   <= decOpB;
			issImm   <= decImm;
			issPc    <= decPc;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		decValid |-> latchFree)
		else $error("decode issued into an occupied latch.");

endmodule

//--- src/mipsDatapath.sv
`timescale 1ns/1ns

module mipsDatapath
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     instrReq,
	input  word_t    instrWord,
	output logic     instrAck,
	input  logic     wbHold,
	output logic     wbValid,
	output regAddr_t wbAddr,
	output word_t    wbData
);

	regAddr_t rdAddrA;
	regAddr_t rdAddrB;
	word_t    rdDataA;
	word_t    rdDataB;
	logic     wrEn;
	regAddr_t wrAddr;
	word_t    wrData;
	logic     latchFree;
	logic     exValid;
	regAddr_t exDest;
	word_t    exResult;
	logic     decValid;
	aluOp_t   decAluOp;
	wbSel_t   decWbSel;
	regAddr_t decDest;
	word_t    decOpA;
	word_t    decOpB;
	word_t    decImm;
	word_t    decPc;
	logic     issValid;
	aluOp_t   issAluOp;
	wbSel_t   issWbSel;
	regAddr_t issDest;
	word_t    issOpA;
	word_t    issOpB;
	word_t    issImm;
	word_t    issPc;

	instrDecode decode (
		.clk(clk), .rstN(rstN),
		.instrReq(instrReq), .instrWord(instrWord), .instrAck(instrAck),
		.latchFree(latchFree),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.exValid(exValid), .exDest(exDest), .exResult(exResult),
		.decValid(decValid), .decAluOp(decAluOp), .decWbSel(decWbSel),
		.decDest(decDest), .decOpA(decOpA), .decOpB(decOpB),
		.decImm(decImm), .decPc(decPc)
	);

	regFile regs (
		.clk(clk), .rstN(rstN),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
	);

	issueLatch latch (
		.clk(clk), .rstN(rstN),
		.decValid(decValid), .decAluOp(decAluOp), .decWbSel(decWbSel),
		.decDest(decDest), .decOpA(decOpA), .decOpB(decOpB),
		.decImm(decImm), .decPc(decPc),
		.wbHold(wbHold), .latchFree(latchFree),
		.issValid(issValid), .issAluOp(issAluOp), .issWbSel(issWbSel),
		.issDest(issDest), .issOpA(issOpA), .issOpB(issOpB),
		.issImm(issImm), .issPc(issPc)
	);

	aluWriteback execute (
		.clk(clk), .rstN(rstN),
		.issValid(issValid), .issAluOp(issAluOp), .issWbSel(issWbSel),
		.issDest(issDest), .issOpA(issOpA), .issOpB(issOpB),
		.issImm(issImm), .issPc(issPc),
		.wbHold(wbHold),
		.exValid(exValid), .exDest(exDest), .exResult(exResult),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

endmodule

//--- src/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [2:0]  aluOp_t;
	typedef logic [1:0]  wbSel_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU operation codes.
	localparam aluOp_t ALU_ADD   = 3'd0;
	localparam aluOp_t ALU_SUB   = 3'd1;
	localparam aluOp_t ALU_AND   = 3'd2;
	localparam aluOp_t ALU_OR    = 3'd3;
	localparam aluOp_t ALU_SLT   = 3'd4;
	localparam aluOp_t ALU_PASSB = 3'd5; // operand B straight through.

	// writeback source codes.
	localparam wbSel_t WB_ALU   = 2'd0;
	localparam wbSel_t WB_UPPER = 2'd1; // immediate moved to bits 31:16.
	localparam wbSel_t WB_LINK  = 2'd2; // instruction counter plus step.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// four-phase receiver states.
	typedef enum logic [1:0] {
		IDLE,
		ACKED,
		WAITLOW
	} hsState_t;

endpackage

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  regAddr_t rdAddrA,
	input  regAddr_t rdAddrB,
	output word_t    rdDataA,
	output word_t    rdDataB,
	input  logic     wrEn,
	input  regAddr_t wrAddr,
	input  word_t    wrData
);

	word_t regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData; // r0 never changes.
		end
	end

	// the write lands at the edge, so a same-cycle read sees the old value.
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- verif/mipsDatapathTb.sv
`timescale 1ns/1ns
`include "mipsDatapath_config.svh"

module mipsDatapathTb
	import mipsPkg::*;
();

	localparam int numEntries = 18;

	logic        clk;
	logic        rstN;
	logic        instrReq;
	word_t       instrWord;
	logic        instrAck;
	logic        wbHold;
	logic        wbValid;
	regAddr_t    wbAddr;
	word_t       wbData;
	logic        runDone;
	logic        forceHold;
	int          errCount;
	int          retired;
	logic [15:0] lfsr;
	int          fill;
	word_t       tblInstr [numEntries];
	regAddr_t    tblAddr [numEntries];
	word_t       tblData [numEntries];
	logic        tblFwd [numEntries];

	mipsDatapath UUT (
		.clk(clk), .rstN(rstN),
		.instrReq(instrReq), .instrWord(instrWord), .instrAck(instrAck),
		.wbHold(wbHold),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	wbChecker #(.numEntries(numEntries)) wbCheck (
		.clk(clk), .rstN(rstN),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
		.expAddr(tblAddr), .expData(tblData),
		.runDone(runDone), .errCount(errCount), .retired(retired)
	);

	always #5 clk = !clk;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic stepLfsr();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1.
		return outBit;
	endfunction

	function automatic int takeBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
			value = (value << 1) | stepLfsr();
		return value;
	endfunction

	function automatic word_t rWord(input logic [5:0] funct, input int rs, input int rt,
			input int rd);
		return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic word_t iWord(input logic [5:0] op, input int rs, input int rt,
			input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	task automatic addEntry(input word_t word, input int addr, input word_t data);
		tblInstr[fill] = word;
		tblAddr[fill]  = addr[4:0];
		tblData[fill]  = data;
		tblFwd[fill]   = 1'b0;
		fill++;
	endtask

	task automatic buildTable();
		fill = 0;
		addEntry(iWord(`MIPS_OP_ADDIU, 0, 1, 16'h0005), 1, 32'h0000_0005);
		addEntry(iWord(`MIPS_OP_ADDIU, 0, 2, 16'hFFFD), 2, 32'hFFFF_FFFD); // sign extended.
		addEntry(rWord(`MIPS_FN_ADDU, 1, 2, 3), 3, 32'h0000_0002); // r2 still in flight.
		addEntry(rWord(`MIPS_FN_SUBU, 3, 1, 4), 4, 32'hFFFF_FFFD);
		addEntry(iWord(`MIPS_OP_ORI, 0, 5, 16'h8F0F), 5, 32'h0000_8F0F); // zero extended.
		addEntry(iWord(`MIPS_OP_LUI, 0, 6, 16'h1234), 6, 32'h1234_0000);
		addEntry(iWord(`MIPS_OP_ORI, 6, 6, 16'h5678), 6, 32'h1234_5678);
		addEntry(rWord(`MIPS_FN_AND, 6, 5, 7), 7, 32'h0000_0608);
		addEntry(rWord(`MIPS_FN_OR, 7, 1, 8), 8, 32'h0000_060D);
		addEntry(rWord(`MIPS_FN_SLT, 2, 1, 9), 9, 32'h0000_0001); // -3 < 5.
		addEntry(rWord(`MIPS_FN_SLT, 1, 2, 10), 10, 32'h0000_0000);
		addEntry({`MIPS_OP_JAL, 26'h000_0010}, 31, 32'h0000_0030); // counter is 44.
		addEntry(iWord(`MIPS_OP_ADDIU, 1, 0, 16'h0007), 0, 32'h0000_000C);
		addEntry(rWord(`MIPS_FN_ADDU, 0, 1, 11), 11, 32'h0000_0005); // r0 must read zero.
		addEntry(rWord(`MIPS_FN_ADDU, 31, 9, 12), 12, 32'h0000_0031);
		addEntry(rWord(`MIPS_FN_SUBU, 0, 12, 13), 13, 32'hFFFF_FFCF);
		addEntry(rWord(`MIPS_FN_SLT, 13, 0, 14), 14, 32'h0000_0001);
		addEntry({`MIPS_OP_JAL, 26'h000_0040}, 31, 32'h0000_0048);
		// these are decoded while the entry before them still sits in the latch.
		tblFwd[2]  = 1'b1;
		tblFwd[6]  = 1'b1;
		tblFwd[13] = 1'b1;
		tblFwd[16] = 1'b1;
	endtask

	// one full four-phase exchange after a random idle gap.
	task automatic sendInstr(input word_t word, input logic releaseHold);
		int gap;
		gap = takeBits(2);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		instrReq  <= 1'b1;
		instrWord <= word;
		@(negedge clk);
		if (releaseHold)
			forceHold = 1'b0; // the held producer retires as this word is accepted.
		while (instrAck !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		instrReq <= 1'b0;
		@(negedge clk);
		while (instrAck !== 1'b0)
			@(negedge clk);
	endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk       = 1'b0;
		rstN      = 1'b0;
		instrReq  = 1'b0;
		instrWord = '0;
		wbHold    = 1'b0;
		runDone   = 1'b0;
		forceHold = 1'b0;
		lfsr      = 16'd37014;
		buildTable();
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < numEntries; i++) begin
			if ((i + 1 < numEntries) && tblFwd[i + 1]) begin
				wait (retired == i); // latch empty before the producer goes in.
				forceHold = 1'b1;
			end
			sendInstr(tblInstr[i], tblFwd[i]);
		end
		wait (retired == numEntries);
		repeat (5) @(posedge clk); // room for a stray extra retirement.
		runDone <= 1'b1;
		repeat (2) @(posedge clk);
		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// random stalls of one to four cycles on the writeback port.
	initial begin : holdGen
		int holdLeft;
		holdLeft = 0;
		@(posedge rstN);
		forever begin
			@(posedge clk);
			if (holdLeft == 0) begin
				if (takeBits(3) == 0)
					holdLeft = 1 + takeBits(2);
			end
			wbHold <= (holdLeft != 0) || forceHold;
			if (holdLeft != 0)
				holdLeft--;
		end
	end

	initial begin : watchdog
		repeat (numEntries * 40) @(posedge clk);
		$display("run timed out after %0d cycles with %0d of %0d retired and %0d errors",
			numEntries * 40, retired, numEntries, errCount);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- verif/wbChecker.sv
`timescale 1ns/1ns

module wbChecker
	import mipsPkg::*;
#(
	parameter int numEntries = 1
)
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     wbValid,
	input  regAddr_t wbAddr,
	input  word_t    wbData,
	input  regAddr_t expAddr [numEntries],
	input  word_t    expData [numEntries],
	input  logic     runDone,
	output int       errCount,
	output int       retired
);

	logic reported;

	// registered DUT outputs are sampled half a cycle after they change.
	always @(negedge clk) begin
		if (!rstN) begin
			errCount = 0;
			retired  = 0;
			reported = 1'b0;
		end else begin
			if (wbValid) begin
				if (retired >= numEntries) begin
					$display("extra retirement to register %0d after all %0d instructions retired",
						wbAddr, numEntries);
					errCount++;
				end else begin
					if (wbAddr !== expAddr[retired]) begin
						$display("CHECK FAILED wbAddr entry %0d expected %h got %h",
							retired, expAddr[retired], wbAddr);
						errCount++;
					end
					if (wbData !== expData[retired]) begin
						$display("CHECK FAILED wbData entry %0d expected %h got %h",
							retired, expData[retired], wbData);
						errCount++;
					end
				end
				retired++;
			end
			if (runDone && !reported) begin
				reported = 1'b1;
				if (retired < numEntries) begin
					$display("missing retirements, only %0d of %0d instructions retired",
						retired, numEntries);
					errCount++;
				end
				$display("wbChecker: %0d retired, %0d expected, %0d errors",
					retired, numEntries, errCount);
			end
		end
	end

endmodule
